// ==== files.f ====
rtl/dmem_pkg.sv
rtl/dcache_tag.sv
rtl/dcache_data.sv
rtl/uncache_ctrl.sv
rtl/mem_side_ctrl.sv
rtl/dmem_top.sv
tb/mem_model.sv
tb/dmem_tb.sv

// ==== rtl/dcache_data.sv ====
`timescale 1ns/10ps
module dcache_data (
    input  logic                        clk,
    input  logic                        rst,
    input  dmem_pkg::cpu_req_t          req_i,
    input  logic [dmem_pkg::WAYS-1:0]   hit_way_i,
    input  logic                        victim_way_i,
    input  dmem_pkg::refill_t           refill_i,
    output logic [dmem_pkg::WORD_W-1:0] rdata_o,
    output dmem_pkg::line_t             victim_line_o
);

    dmem_pkg::line_t              lines_q [dmem_pkg::WAYS][dmem_pkg::SETS];
    logic [dmem_pkg::INDEX_W-1:0] idx;
    logic                         hit_idx;
    dmem_pkg::line_t              hit_line;
    logic [dmem_pkg::WORD_W-1:0]  hit_word;
    logic [dmem_pkg::WORD_W-1:0]  merged_word;
    dmem_pkg::line_t              merged_line;

    assign idx     = req_i.addr.index;
    assign hit_idx = hit_way_i[1];

    always_comb begin
        hit_line = lines_q[hit_idx][idx];
        hit_word = hit_line[req_i.addr.word * dmem_pkg::WORD_W +: dmem_pkg::WORD_W];
        // byte lanes picked by sel
        for (int b = 0; b < dmem_pkg::WORD_W / 8; b++) begin
            merged_word[8*b +: 8] = req_i.sel[b] ? req_i.wdata[8*b +: 8] : hit_word[8*b +: 8];
        end
        merged_line = hit_line;
        merged_line[req_i.addr.word * dmem_pkg::WORD_W +: dmem_pkg::WORD_W] = merged_word;
    end

    // refill and store hit never share a cycle
    always_ff @(posedge clk) begin
        if (refill_i.refresh) begin
            lines_q[refill_i.way][idx] <= refill_i.line;
        end else if ((|hit_way_i) && req_i.wen) begin
            lines_q[hit_idx][idx] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_o <= '0;
        end else if (|hit_way_i) begin
            rdata_o <= hit_word;
        end
    end

    assign victim_line_o = lines_q[victim_way_i][idx];

endmodule

// ==== rtl/dcache_tag.sv ====
`timescale 1ns/10ps
module dcache_tag (
    input  logic                        clk,
    input  logic                        rst,
    input  dmem_pkg::cpu_req_t          req_i,
    input  dmem_pkg::refill_t           refill_i,
    output logic [dmem_pkg::WAYS-1:0]   hit_way_o,
    output logic                        miss_o,
    output logic                        write_back_o,
    output logic                        victim_way_o,
    output logic [dmem_pkg::ADDR_W-1:0] victim_addr_o,
    output logic [dmem_pkg::ADDR_W-1:0] refill_addr_o,
    output logic                        stallreq_o
);

    logic [dmem_pkg::TAG_W-1:0]   tag_q   [dmem_pkg::WAYS][dmem_pkg::SETS];
    logic [dmem_pkg::SETS-1:0]    valid_q [dmem_pkg::WAYS];
    logic [dmem_pkg::SETS-1:0]    dirty_q [dmem_pkg::WAYS];
    // set bit names the least recently used way
    logic [dmem_pkg::SETS-1:0]    lru_q;
    logic [dmem_pkg::INDEX_W-1:0] idx;
    logic                         lookup;
    logic                         hit_idx;

    assign idx    = req_i.addr.index;
    assign lookup = req_i.en & ~req_i.uncached;

    always_comb begin
        for (int w = 0; w < dmem_pkg::WAYS; w++) begin
            hit_way_o[w] = lookup & valid_q[w][idx] & (tag_q[w][idx] == req_i.addr.tag);
        end
    end

    assign hit_idx    = hit_way_o[1];
    assign miss_o     = lookup & ~(|hit_way_o);
    assign stallreq_o = miss_o;

    // empty ways fill before any valid line is evicted
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[idx];
        end
    end

    assign write_back_o = miss_o & valid_q[victim_way_o][idx] & dirty_q[victim_way_o][idx];

    assign victim_addr_o = {tag_q[victim_way_o][idx], idx, {dmem_pkg::OFFSET_W{1'b0}}};
    assign refill_addr_o = {req_i.addr.tag, idx, {dmem_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (refill_i.refresh) begin
            tag_q[refill_i.way][idx] <= req_i.addr.tag;
        end
    end

    // nothing else stalls a cached request, so every hit is accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dmem_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (refill_i.refresh) begin
                valid_q[refill_i.way][idx] <= 1'b1;
                dirty_q[refill_i.way][idx] <= 1'b0;
            end
            if (|hit_way_o) begin
                lru_q[idx] <= ~hit_idx;
                if (req_i.wen) begin
                    dirty_q[hit_idx][idx] <= 1'b1;
                end
            end
        end
    end

    // a tag is never installed twice in one set
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way_o))
        else $error("both ways hit in set %0d", idx);

endmodule

// ==== rtl/dmem_pkg.sv ====
package dmem_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int SETS       = 16;
    localparam int WAYS       = 2;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-3:0] word;
        logic [1:0]          boff;
    } addr_t;

    typedef struct packed {
        logic              en;
        logic              wen;
        logic [3:0]        sel;
        addr_t             addr;
        logic [WORD_W-1:0] wdata;
        logic              uncached;
    } cpu_req_t;

    // word 0 sits in the low bits
    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic              word;
        logic [ADDR_W-1:0] addr;
        logic [3:0]        sel;
        line_t             wline;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        line_t rline;
    } mem_rsp_t;

    typedef struct packed {
        logic  refresh;
        logic  way;
        line_t line;
    } refill_t;

endpackage

// ==== rtl/dmem_top.sv ====
`timescale 1ns/10ps
module dmem_top (
    input  logic                        clk,
    input  logic                        rst,
    input  dmem_pkg::cpu_req_t          cpu_req_i,
    output logic                        stallreq_o,
    output logic [dmem_pkg::WORD_W-1:0] rdata_o,
    output dmem_pkg::mem_req_t          mem_req_o,
    input  dmem_pkg::mem_rsp_t          mem_rsp_i
);

    logic [dmem_pkg::WAYS-1:0]   hit_way;
    logic                        miss;
    logic                        write_back;
    logic                        victim_way;
    logic [dmem_pkg::ADDR_W-1:0] victim_addr;
    logic [dmem_pkg::ADDR_W-1:0] refill_addr;
    logic                        stallreq_cache;
    logic                        stallreq_uncache;
    dmem_pkg::line_t             victim_line;
    dmem_pkg::refill_t           refill;
    logic                        word_req;
    logic                        word_ack;
    logic [dmem_pkg::WORD_W-1:0] cache_rdata;
    logic [dmem_pkg::WORD_W-1:0] uncache_rdata;
    logic                        uncached_q;

    assign stallreq_o = stallreq_cache | stallreq_uncache;

    // source of the word returned one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            uncached_q <= 1'b0;
        end else if (cpu_req_i.en && !stallreq_o) begin
            uncached_q <= cpu_req_i.uncached;
        end
    end

    assign rdata_o = uncached_q ? uncache_rdata : cache_rdata;

    dcache_tag dcache_tag_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (cpu_req_i),
        .refill_i      (refill),
        .hit_way_o     (hit_way),
        .miss_o        (miss),
        .write_back_o  (write_back),
        .victim_way_o  (victim_way),
        .victim_addr_o (victim_addr),
        .refill_addr_o (refill_addr),
        .stallreq_o    (stallreq_cache)
    );

    dcache_data dcache_data_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (cpu_req_i),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .refill_i      (refill),
        .rdata_o       (cache_rdata),
        .victim_line_o (victim_line)
    );

    uncache_ctrl uncache_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req_i      (cpu_req_i),
        .ack_i      (word_ack),
        .ack_word_i (mem_rsp_i.rline[dmem_pkg::WORD_W-1:0]),
        .word_req_o (word_req),
        .stallreq_o (stallreq_uncache),
        .rdata_o    (uncache_rdata)
    );

    mem_side_ctrl mem_side_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (cpu_req_i),
        .miss_i        (miss),
        .write_back_i  (write_back),
        .victim_way_i  (victim_way),
        .victim_addr_i (victim_addr),
        .refill_addr_i (refill_addr),
        .victim_line_i (victim_line),
        .word_req_i    (word_req),
        .mem_req_o     (mem_req_o),
        .mem_rsp_i     (mem_rsp_i),
        .refill_o      (refill),
        .word_ack_o    (word_ack)
    );

endmodule

// ==== rtl/mem_side_ctrl.sv ====
`timescale 1ns/10ps
module mem_side_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  dmem_pkg::cpu_req_t          req_i,
    input  logic                        miss_i,
    input  logic                        write_back_i,
    input  logic                        victim_way_i,
    input  logic [dmem_pkg::ADDR_W-1:0] victim_addr_i,
    input  logic [dmem_pkg::ADDR_W-1:0] refill_addr_i,
    input  dmem_pkg::line_t             victim_line_i,
    input  logic                        word_req_i,
    output dmem_pkg::mem_req_t          mem_req_o,
    input  dmem_pkg::mem_rsp_t          mem_rsp_i,
    output dmem_pkg::refill_t           refill_o,
    output logic                        word_ack_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WB,
        S_REFILL,
        S_WORD
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (miss_i) begin
                    state_d = write_back_i ? S_WB : S_REFILL;
                end else if (word_req_i) begin
                    state_d = S_WORD;
                end
            end
            // dirty victim goes out before the refill read
            S_WB:     state_d = mem_rsp_i.ack ? S_REFILL : S_WB;
            S_REFILL: state_d = mem_rsp_i.ack ? S_IDLE : S_REFILL;
            S_WORD:   state_d = mem_rsp_i.ack ? S_IDLE : S_WORD;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request fields follow the state, so they hold until ack
    always_comb begin
        mem_req_o = '0;
        case (state_q)
            S_WB: begin
                mem_req_o.wr    = 1'b1;
                mem_req_o.addr  = victim_addr_i;
                mem_req_o.sel   = 4'hf;
                mem_req_o.wline = victim_line_i;
            end
            S_REFILL: begin
                mem_req_o.rd   = 1'b1;
                mem_req_o.addr = refill_addr_i;
                mem_req_o.sel  = 4'hf;
            end
            S_WORD: begin
                mem_req_o.rd    = ~req_i.wen;
                mem_req_o.wr    = req_i.wen;
                mem_req_o.word  = 1'b1;
                mem_req_o.addr  = req_i.addr;
                mem_req_o.sel   = req_i.sel;
                mem_req_o.wline = {{(dmem_pkg::LINE_W - dmem_pkg::WORD_W){1'b0}}, req_i.wdata};
            end
            default: mem_req_o = '0;
        endcase
    end

    assign refill_o.refresh = (state_q == S_REFILL) & mem_rsp_i.ack;
    assign refill_o.way     = victim_way_i;
    assign refill_o.line    = mem_rsp_i.rline;
    assign word_ack_o       = (state_q == S_WORD) & mem_rsp_i.ack;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req_o.rd && mem_req_o.wr))
        else $error("memory read and write requested together");

endmodule

// ==== rtl/uncache_ctrl.sv ====
`timescale 1ns/10ps
module uncache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  dmem_pkg::cpu_req_t          req_i,
    input  logic                        ack_i,
    input  logic [dmem_pkg::WORD_W-1:0] ack_word_i,
    output logic                        word_req_o,
    output logic                        stallreq_o,
    output logic [dmem_pkg::WORD_W-1:0] rdata_o
);

    // set for the one cycle after ack, when the held request is accepted
    logic done_q;

    assign word_req_o = req_i.en & req_i.uncached & ~done_q;
    assign stallreq_o = word_req_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= ack_i;
        end
    end

    // returned word stays put until the next uncached read
    always_ff @(posedge clk) begin
        if (ack_i && !req_i.wen) begin
            rdata_o <= ack_word_i;
        end
    end

    a_ack_outstanding: assert property (@(posedge clk) disable iff (rst) ack_i |-> word_req_o)
        else $error("word ack with no uncached access outstanding");

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the data memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module dmem_tb -Mdir obj_dir -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vdmem_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// ==== tb/dmem_tb.sv ====
`timescale 1ns/10ps
module dmem_tb;

    logic               clk;
    logic               rst;
    dmem_pkg::cpu_req_t cpu_req;
    logic               stallreq;
    logic [31:0]        rdata;
    dmem_pkg::mem_req_t mem_req;
    dmem_pkg::mem_rsp_t mem_rsp;
    logic               poke;
    logic [31:0]        poke_addr;
    logic [31:0]        poke_data;
    dmem_pkg::mem_req_t last_rd;
    dmem_pkg::mem_req_t last_wr;
    int                 rd_count;
    int                 wr_count;
    // stall cycles seen by the most recent access
    int                 stall_cycles;

    always #4 clk = ~clk;

    dmem_top dmem_top_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (cpu_req),
        .stallreq_o (stallreq),
        .rdata_o    (rdata),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    mem_model mem_model_i (
        .clk         (clk),
        .rst         (rst),
        .req_i       (mem_req),
        .rsp_o       (mem_rsp),
        .poke_i      (poke),
        .poke_addr_i (poke_addr),
        .poke_data_i (poke_data),
        .last_rd_o   (last_rd),
        .last_wr_o   (last_wr),
        .rd_count_o  (rd_count),
        .wr_count_o  (wr_count)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem_model_i.mem[addr[13:2]];
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // holds the request until the stall drops, then returns the word after acceptance
    task automatic cpu_access(input logic wen, input logic uncached, input logic [31:0] addr,
                              input logic [3:0] sel, input logic [31:0] wdata,
                              output logic [31:0] data);
        int cycles;
        @(posedge clk);
        #1;
        cpu_req.en       = 1'b1;
        cpu_req.wen      = wen;
        cpu_req.sel      = sel;
        cpu_req.addr     = addr;
        cpu_req.wdata    = wdata;
        cpu_req.uncached = uncached;
        cycles = 0;
        @(negedge clk);
        while (stallreq && cycles < 100) begin
            cycles++;
            @(negedge clk);
        end
        if (stallreq) begin
            $display("stall still high 100 cycles after request to %h at %0t", addr, $time);
            abort_run();
        end
        stall_cycles = cycles;
        @(posedge clk);
        #1;
        cpu_req.en = 1'b0;
        @(negedge clk);
        data = rdata;
    endtask

    task automatic load_word(input logic [31:0] addr, input logic uncached,
                             output logic [31:0] data);
        cpu_access(1'b0, uncached, addr, 4'hf, 32'h0, data);
    endtask

    task automatic store_word(input logic [31:0] addr, input logic uncached,
                              input logic [3:0] sel, input logic [31:0] wdata);
        logic [31:0] unused;
        cpu_access(1'b1, uncached, addr, sel, wdata, unused);
    endtask

    task automatic poke_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        poke      = 1'b1;
        poke_addr = addr;
        poke_data = data;
        @(posedge clk);
        #1;
        poke = 1'b0;
    endtask

    task automatic cold_load_miss();
        logic [31:0] data;
        int          rd0;
        rd0 = rd_count;
        load_word(32'h0000_0134, 1'b0, data);
        // a miss stalls from its request cycle
        check_word("stallreq_o", 32'd1, 32'(stall_cycles > 0));
        check_word("rd_count", rd0 + 1, rd_count);
        check_word("last_rd.addr", 32'h0000_0130, last_rd.addr);
        check_word("last_rd.word", 32'd0, 32'(last_rd.word));
        check_word("rdata_o", mem_word(32'h0000_0134), data);
    endtask

    task automatic hit_without_traffic();
        logic [31:0] data;
        int          rd0;
        rd0 = rd_count;
        load_word(32'h0000_013c, 1'b0, data);
        check_word("stallreq_o", 32'd0, 32'(stall_cycles));
        check_word("rdata_o", mem_word(32'h0000_013c), data);
        check_word("rd_count", rd0, rd_count);
    endtask

    task automatic byte_store_merge();
        logic [31:0] data;
        int          wr0;
        wr0 = wr_count;
        store_word(32'h0000_0138, 1'b0, 4'b0110, 32'ha5c3_96e1);
        load_word(32'h0000_0138, 1'b0, data);
        check_word("rdata_o", merge_bytes(mem_word(32'h0000_0138), 32'ha5c3_96e1, 4'b0110), data);
        check_word("wr_count", wr0, wr_count);
    endtask

    task automatic dirty_lru_eviction();
        logic [31:0] data;
        logic [31:0] b_word;
        logic [31:0] b_line [4];
        int          rd0;
        int          wr0;
        // set 3 way 0 holds the dirty line at 0x130, way 1 gets 0x230
        load_word(32'h0000_0230, 1'b0, data);
        store_word(32'h0000_0234, 1'b0, 4'b1001, 32'h1234_5678);
        // touching 0x130 leaves way 1 least recently used
        load_word(32'h0000_013c, 1'b0, data);
        b_word = merge_bytes(mem_word(32'h0000_0234), 32'h1234_5678, 4'b1001);
        for (int w = 0; w < 4; w++) begin
            b_line[w] = mem_word(32'h0000_0230 + 32'(4 * w));
        end
        b_line[1] = b_word;
        rd0 = rd_count;
        wr0 = wr_count;
        load_word(32'h0000_0338, 1'b0, data);
        check_word("wr_count", wr0 + 1, wr_count);
        check_word("last_wr.addr", 32'h0000_0230, last_wr.addr);
        for (int w = 0; w < 4; w++) begin
            check_word("last_wr.wline", b_line[w], last_wr.wline[32*w +: 32]);
        end
        check_word("rd_count", rd0 + 1, rd_count);
        check_word("last_rd.addr", 32'h0000_0330, last_rd.addr);
        check_word("rdata_o", mem_word(32'h0000_0338), data);
        // the dirty line at 0x130 is now the victim
        wr0 = wr_count;
        load_word(32'h0000_0234, 1'b0, data);
        check_word("last_wr.addr", 32'h0000_0130, last_wr.addr);
        check_word("wr_count", wr0 + 1, wr_count);
        check_word("rdata_o", b_word, data);
    endtask

    task automatic uncached_access();
        logic [31:0] data;
        logic [31:0] old_word;
        logic [31:0] cached_word;
        logic [31:0] new_word;
        int          rd0;
        int          wr0;
        old_word = mem_word(32'h0000_0410);
        wr0 = wr_count;
        store_word(32'h0000_0410, 1'b1, 4'b0011, 32'hdead_beef);
        check_word("wr_count", wr0 + 1, wr_count);
        check_word("last_wr.addr", 32'h0000_0410, last_wr.addr);
        check_word("last_wr.word", 32'd1, 32'(last_wr.word));
        check_word("last_wr.sel", 32'h3, 32'(last_wr.sel));
        check_word("last_wr.wline", 32'hdead_beef, last_wr.wline[31:0]);
        cached_word = merge_bytes(old_word, 32'hdead_beef, 4'b0011);
        load_word(32'h0000_0410, 1'b0, data);
        check_word("rdata_o", cached_word, data);
        // memory changes behind the cached copy
        new_word = ~cached_word;
        poke_word(32'h0000_0410, new_word);
        rd0 = rd_count;
        load_word(32'h0000_0410, 1'b1, data);
        check_word("stallreq_o", 32'd1, 32'(stall_cycles > 0));
        check_word("rd_count", rd0 + 1, rd_count);
        check_word("last_rd.word", 32'd1, 32'(last_rd.word));
        check_word("rdata_o", new_word, data);
        rd0 = rd_count;
        load_word(32'h0000_0410, 1'b0, data);
        check_word("rdata_o", cached_word, data);
        check_word("rd_count", rd0, rd_count);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_req   = '0;
        poke      = 1'b0;
        poke_addr = '0;
        poke_data = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        cold_load_miss();
        hit_without_traffic();
        byte_store_merge();
        dirty_lru_eviction();
        uncached_access();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/10ps
module mem_model (
    input  logic               clk,
    input  logic               rst,
    input  dmem_pkg::mem_req_t req_i,
    output dmem_pkg::mem_rsp_t rsp_o,
    input  logic               poke_i,
    input  logic [31:0]        poke_addr_i,
    input  logic [31:0]        poke_data_i,
    output dmem_pkg::mem_req_t last_rd_o,
    output dmem_pkg::mem_req_t last_wr_o,
    output int                 rd_count_o,
    output int                 wr_count_o
);

    // 16 KB of words, addressed by bits 13:2
    logic [31:0] mem [4096];
    logic [11:0] base;
    logic [31:0] word_tmp;
    int          wait_q;
    int          seed;

    initial begin
        seed = 32'hc949752f;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = $random(seed);
        end
    end

    // ack comes three cycles after the request is first seen
    always @(posedge clk) begin
        rsp_o.ack <= 1'b0;
        if (rst) begin
            wait_q     <= 0;
            rd_count_o <= 0;
            wr_count_o <= 0;
            last_rd_o  <= '0;
            last_wr_o  <= '0;
            rsp_o      <= '0;
        end else begin
            if (poke_i) begin
                mem[poke_addr_i[13:2]] <= poke_data_i;
            end
            if ((req_i.rd || req_i.wr) && !rsp_o.ack) begin
                if (wait_q < 3) begin
                    wait_q <= wait_q + 1;
                end else begin
                    wait_q    <= 0;
                    rsp_o.ack <= 1'b1;
                    base = req_i.addr[13:2];
                    if (req_i.wr) begin
                        wr_count_o <= wr_count_o + 1;
                        last_wr_o  <= req_i;
                        if (req_i.word) begin
                            word_tmp = mem[base];
                            for (int b = 0; b < 4; b++) begin
                                if (req_i.sel[b]) begin
                                    word_tmp[8*b +: 8] = req_i.wline[8*b +: 8];
                                end
                            end
                            mem[base] <= word_tmp;
                        end else begin
                            for (int w = 0; w < 4; w++) begin
                                mem[{base[11:2], w[1:0]}] <= req_i.wline[32*w +: 32];
                            end
                        end
                    end else begin
                        rd_count_o <= rd_count_o + 1;
                        last_rd_o  <= req_i;
                        if (req_i.word) begin
                            rsp_o.rline <= {96'b0, mem[base]};
                        end else begin
                            for (int w = 0; w < 4; w++) begin
                                rsp_o.rline[32*w +: 32] <= mem[{base[11:2], w[1:0]}];
                            end
                        end
                    end
                end
            end
        end
    end

endmodule
